// ==== include/msr_consts.svh ====
// ==================================================
// MSR block constants
// Widths, register map and CPUID fields
// ==================================================
`ifndef MSR_CONSTS_SVH
`define MSR_CONSTS_SVH

`define MSR_DW          32
`define MSR_PSR_DW      10
`define MSR_SR_NUM      4
`define MSR_AW          6

// Byte addresses on the bus
`define MSR_ADDR_PSR    6'h00
`define MSR_ADDR_EPSR   6'h04
`define MSR_ADDR_EPC    6'h08
`define MSR_ADDR_ELSA   6'h0C
`define MSR_ADDR_CPUID  6'h10
`define MSR_ADDR_COREID 6'h14
`define MSR_ADDR_SR0    6'h20

// CPUID fields, feature bits from imm up to tsc
`define MSR_CPUID_VER   8'd1
`define MSR_CPUID_REV   10'd0
`define MSR_CPUID_FEAT  8'b11000011

`endif

// ==== source/msr_pkg.sv ====
// ==================================================
// MSR types
// PSR layout and register write requests
// ==================================================
`include "msr_consts.svh"

package msr_pkg;

   // Named PSR bits, MSB first
   typedef struct packed {
      logic       dce;
      logic       ice;
      logic       dmme;
      logic       imme;
      logic       ire;
      logic       rm;
      logic [3:0] rsv;
   } psr_bits_t;

   // Same word seen as raw vector or as named bits
   typedef union packed {
      logic [`MSR_PSR_DW-1:0] raw;
      psr_bits_t              bits;
   } psr_word_t;

   // SR targets sit in the upper half of the encoding
   typedef enum logic [2:0] {
      SEL_PSR, SEL_EPSR, SEL_EPC, SEL_ELSA,
      SEL_SR0, SEL_SR1, SEL_SR2, SEL_SR3
   } msr_sel_t;

   typedef struct packed {
      logic               valid;
      msr_sel_t           sel;
      logic [`MSR_DW-1:0] data;
   } msr_wreq_t;

endpackage

// ==== source/axil_pkg.sv ====
// ==================================================
// AXI4-Lite channel types
// ==================================================
`include "msr_consts.svh"

package axil_pkg;

   typedef enum logic [1:0] {
      AXIL_OKAY   = 2'b00,
      AXIL_EXOKAY = 2'b01,
      AXIL_SLVERR = 2'b10,
      AXIL_DECERR = 2'b11
   } axil_resp_t;

   // Master side
   typedef struct packed {
      logic                   awvalid;
      logic [`MSR_AW-1:0]     awaddr;
      logic                   wvalid;
      logic [`MSR_DW-1:0]     wdata;
      logic [`MSR_DW/8-1:0]   wstrb;
      logic                   bready;
      logic                   arvalid;
      logic [`MSR_AW-1:0]     araddr;
      logic                   rready;
   } axil_req_t;

   // Slave side
   typedef struct packed {
      logic                   awready;
      logic                   wready;
      logic                   bvalid;
      axil_resp_t             bresp;
      logic                   arready;
      logic                   rvalid;
      logic [`MSR_DW-1:0]     rdata;
      axil_resp_t             rresp;
   } axil_rsp_t;

endpackage

// ==== source/ex_psr.sv ====
// ==================================================
// Machine state registers
// PSR, EPSR, EPC, ELSA, SRs with write-through bypass
// ==================================================
`timescale 1ns/100ps
`include "msr_consts.svh"

module ex_psr (
   input  logic                          clk,
   input  logic                          rst,
   // PSR
   input  logic                          exc_ent,
   input  logic [5:0]                    psr_we,
   input  msr_pkg::psr_word_t            psr_nxt,
   output msr_pkg::psr_word_t            psr,
   output msr_pkg::psr_word_t            psr_nold,
   // EPSR
   input  msr_pkg::psr_word_t            epsr_nxt,
   input  logic                          epsr_we,
   output msr_pkg::psr_word_t            epsr,
   // EPC
   input  logic [`MSR_DW-1:0]            epc_nxt,
   input  logic                          epc_we,
   output logic [`MSR_DW-1:0]            epc,
   // ELSA
   input  logic [`MSR_DW-1:0]            elsa_nxt,
   input  logic                          elsa_we,
   output logic [`MSR_DW-1:0]            elsa,
   // SR
   input  logic [`MSR_DW-1:0]            sr_nxt,
   input  logic [`MSR_SR_NUM-1:0]        sr_we,
   output logic [`MSR_SR_NUM*`MSR_DW-1:0] sr,
   // Read-only IDs
   output logic [`MSR_DW-1:0]            cpuid,
   output logic [`MSR_DW-1:0]            coreid
);

   localparam int NAMED = 6;
   localparam int RSV   = `MSR_PSR_DW - NAMED;

   msr_pkg::psr_word_t     psr_ff;
   msr_pkg::psr_word_t     psr_byp;
   msr_pkg::psr_word_t     psr_ent;
   msr_pkg::psr_word_t     epsr_ff;
   logic [`MSR_DW-1:0]     epc_ff;
   logic [`MSR_DW-1:0]     elsa_ff;
   logic [`MSR_DW-1:0]     sr_ff [`MSR_SR_NUM];

   // Bypass of each named bit with reserved bits held at zero
   always_comb begin
      psr_byp.raw = '0;
      for (int i = 0; i < NAMED; i++) begin
         psr_byp.raw[RSV+i] = psr_we[i] ? psr_nxt.raw[RSV+i] : psr_ff.raw[RSV+i];
      end
   end

   // Exception entry overrides the mode and translation bits
   always_comb begin
      psr_ent = psr_byp;
      if (exc_ent) begin
         psr_ent.bits.rm   = 1'b1;
         psr_ent.bits.ire  = 1'b0;
         psr_ent.bits.imme = 1'b0;
         psr_ent.bits.dmme = 1'b0;
      end
   end

   // No PSR write enable is set in an exception cycle
   assign psr      = psr_ent;
   assign psr_nold = psr_ff;

   always_ff @(posedge clk) begin
      if (rst) begin
         psr_ff.bits <= '{rm: 1'b1, default: '0};
         epsr_ff     <= '0;
         epc_ff      <= '0;
         elsa_ff     <= '0;
      end else begin
         psr_ff <= psr_ent;
         if (epsr_we) begin
            epsr_ff <= epsr_nxt;
         end
         if (epc_we) begin
            epc_ff <= epc_nxt;
         end
         if (elsa_we) begin
            elsa_ff <= elsa_nxt;
         end
      end
   end

   // Scratch registers
   always_ff @(posedge clk) begin
      for (int i = 0; i < `MSR_SR_NUM; i++) begin
         if (sr_we[i]) begin
            sr_ff[i] <= sr_nxt;
         end
      end
   end

   assign epsr = epsr_we ? epsr_nxt : epsr_ff;
   assign epc  = epc_we ? epc_nxt : epc_ff;
   assign elsa = elsa_we ? elsa_nxt : elsa_ff;

   always_comb begin
      for (int i = 0; i < `MSR_SR_NUM; i++) begin
         sr[i*`MSR_DW +: `MSR_DW] = sr_we[i] ? sr_nxt : sr_ff[i];
      end
   end

   assign cpuid  = {{(`MSR_DW-26){1'b0}}, `MSR_CPUID_FEAT, `MSR_CPUID_REV, `MSR_CPUID_VER};
   assign coreid = '0;

endmodule

// ==== source/exc_ctrl.sv ====
// ==================================================
// Exception controller
// Steers exception entry, return and bus writes
// ==================================================
`timescale 1ns/100ps
`include "msr_consts.svh"

module exc_ctrl (
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    exc_req,
   input  logic [`MSR_DW-1:0]      exc_pc,
   input  logic [`MSR_DW-1:0]      exc_lsa,
   input  logic                    eret,
   input  msr_pkg::msr_wreq_t      wreq,
   output logic                    wreq_ready,
   output logic                    wdone,
   input  msr_pkg::psr_word_t      psr_nold,
   input  msr_pkg::psr_word_t      epsr,
   output logic                    exc_ent,
   output logic [5:0]              psr_we,
   output msr_pkg::psr_word_t      psr_nxt,
   output msr_pkg::psr_word_t      epsr_nxt,
   output logic                    epsr_we,
   output logic [`MSR_DW-1:0]      epc_nxt,
   output logic                    epc_we,
   output logic [`MSR_DW-1:0]      elsa_nxt,
   output logic                    elsa_we,
   output logic [`MSR_DW-1:0]      sr_nxt,
   output logic [`MSR_SR_NUM-1:0]  sr_we
);

   msr_pkg::msr_wreq_t hold_q;
   msr_pkg::msr_wreq_t cur;
   msr_pkg::psr_word_t bus_psr;
   logic               busy;
   logic               commit;

   // Held write goes first since no new one can arrive while it waits
   assign cur        = hold_q.valid ? hold_q : wreq;
   assign busy       = exc_req | eret;
   assign commit     = cur.valid & ~busy;
   assign wreq_ready = ~hold_q.valid;
   assign wdone      = commit;
   assign exc_ent    = exc_req;

   always_comb begin
      bus_psr.raw      = cur.data[`MSR_PSR_DW-1:0];
      bus_psr.bits.rsv = '0;
   end

   // On exception entry the PSR bits are forced inside the register file
   always_comb begin
      psr_we  = '0;
      psr_nxt = bus_psr;
      if (eret & ~exc_req) begin
         psr_we  = '1;
         psr_nxt = epsr;
      end else if (commit && cur.sel == msr_pkg::SEL_PSR) begin
         psr_we = '1;
      end
   end

   // Saved state on exception entry
   always_comb begin
      epsr_we  = 1'b0;
      epsr_nxt = bus_psr;
      epc_we   = 1'b0;
      epc_nxt  = cur.data;
      elsa_we  = 1'b0;
      elsa_nxt = cur.data;
      if (exc_req) begin
         epsr_we  = 1'b1;
         epsr_nxt = psr_nold;
         epc_we   = 1'b1;
         epc_nxt  = exc_pc;
         elsa_we  = 1'b1;
         elsa_nxt = exc_lsa;
      end else if (commit) begin
         epsr_we = (cur.sel == msr_pkg::SEL_EPSR);
         epc_we  = (cur.sel == msr_pkg::SEL_EPC);
         elsa_we = (cur.sel == msr_pkg::SEL_ELSA);
      end
   end

   always_comb begin
      sr_we  = '0;
      sr_nxt = cur.data;
      if (commit && cur.sel[2]) begin
         sr_we[cur.sel[1:0]] = 1'b1;
      end
   end

   // One-entry hold for a write that collides with an exception event
   always_ff @(posedge clk) begin
      if (rst) begin
         hold_q.valid <= 1'b0;
      end else begin
         hold_q.valid <= busy & cur.valid;
      end
      if (busy & cur.valid) begin
         hold_q.sel  <= cur.sel;
         hold_q.data <= cur.data;
      end
   end

endmodule

// ==== source/msr_axil_port.sv ====
// ==================================================
// AXI4-Lite slave for the MSR block
// ==================================================
`timescale 1ns/100ps
`include "msr_consts.svh"

module msr_axil_port (
   input  logic                           clk,
   input  logic                           rst,
   input  axil_pkg::axil_req_t            bus_req,
   output axil_pkg::axil_rsp_t            bus_rsp,
   output msr_pkg::msr_wreq_t             wreq,
   input  logic                           wreq_ready,
   input  logic                           wdone,
   input  msr_pkg::psr_word_t             psr,
   input  msr_pkg::psr_word_t             epsr,
   input  logic [`MSR_DW-1:0]             epc,
   input  logic [`MSR_DW-1:0]             elsa,
   input  logic [`MSR_DW-1:0]             cpuid,
   input  logic [`MSR_DW-1:0]             coreid,
   input  logic [`MSR_SR_NUM*`MSR_DW-1:0] sr
);

   logic                 aw_rdy_q;
   logic                 w_busy;
   logic                 w_hs;
   logic                 bad_q;
   logic                 bvalid_q;
   axil_pkg::axil_resp_t bresp_q;
   logic                 ar_hs;
   logic                 rvalid_q;
   logic [`MSR_DW-1:0]   rdata_q;
   axil_pkg::axil_resp_t rresp_q;
   logic [`MSR_DW-1:0]   rd_word;
   logic                 rd_ok;
   msr_pkg::msr_sel_t    wr_sel;
   logic                 wr_ok;
   msr_pkg::msr_wreq_t   wreq_q;

   assign w_hs  = aw_rdy_q & bus_req.awvalid & bus_req.wvalid;
   assign ar_hs = bus_req.arvalid & ~rvalid_q;

   // Read decode on bypassed values
   always_comb begin
      rd_word = '0;
      rd_ok   = 1'b1;
      case (bus_req.araddr)
         `MSR_ADDR_PSR:    rd_word = `MSR_DW'(psr.raw);
         `MSR_ADDR_EPSR:   rd_word = `MSR_DW'(epsr.raw);
         `MSR_ADDR_EPC:    rd_word = epc;
         `MSR_ADDR_ELSA:   rd_word = elsa;
         `MSR_ADDR_CPUID:  rd_word = cpuid;
         `MSR_ADDR_COREID: rd_word = coreid;
         default: begin
            rd_ok = 1'b0;
            for (int i = 0; i < `MSR_SR_NUM; i++) begin
               if (bus_req.araddr == `MSR_AW'(`MSR_ADDR_SR0 + 4 * i)) begin
                  rd_word = sr[i*`MSR_DW +: `MSR_DW];
                  rd_ok   = 1'b1;
               end
            end
         end
      endcase
   end

   // Write decode, IDs are read-only; full-word writes, strobes not decoded
   always_comb begin
      wr_sel = msr_pkg::SEL_PSR;
      wr_ok  = 1'b1;
      case (bus_req.awaddr)
         `MSR_ADDR_PSR:  wr_sel = msr_pkg::SEL_PSR;
         `MSR_ADDR_EPSR: wr_sel = msr_pkg::SEL_EPSR;
         `MSR_ADDR_EPC:  wr_sel = msr_pkg::SEL_EPC;
         `MSR_ADDR_ELSA: wr_sel = msr_pkg::SEL_ELSA;
         default: begin
            wr_ok = 1'b0;
            for (int i = 0; i < `MSR_SR_NUM; i++) begin
               if (bus_req.awaddr == `MSR_AW'(`MSR_ADDR_SR0 + 4 * i)) begin
                  wr_sel = msr_pkg::msr_sel_t'(int'(msr_pkg::SEL_SR0) + i);
                  wr_ok  = 1'b1;
               end
            end
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         aw_rdy_q     <= 1'b0;
         w_busy       <= 1'b0;
         wreq_q.valid <= 1'b0;
         bad_q        <= 1'b0;
         bvalid_q     <= 1'b0;
         rvalid_q     <= 1'b0;
      end else begin
         // One-cycle ready pulse, then wait for the response to drain
         aw_rdy_q <= ~aw_rdy_q & ~w_busy & wreq_ready & bus_req.awvalid & bus_req.wvalid;
         if (w_hs) begin
            w_busy <= 1'b1;
         end else if (bvalid_q & bus_req.bready) begin
            w_busy <= 1'b0;
         end
         wreq_q.valid <= w_hs & wr_ok;
         bad_q        <= w_hs & ~wr_ok;
         if (wdone | bad_q) begin
            bvalid_q <= 1'b1;
         end else if (bus_req.bready) begin
            bvalid_q <= 1'b0;
         end
         if (ar_hs) begin
            rvalid_q <= 1'b1;
         end else if (bus_req.rready) begin
            rvalid_q <= 1'b0;
         end
      end
      if (w_hs) begin
         wreq_q.sel  <= wr_sel;
         wreq_q.data <= bus_req.wdata;
      end
      if (wdone | bad_q) begin
         bresp_q <= bad_q ? axil_pkg::AXIL_SLVERR : axil_pkg::AXIL_OKAY;
      end
      if (ar_hs) begin
         rdata_q <= rd_word;
         rresp_q <= rd_ok ? axil_pkg::AXIL_OKAY : axil_pkg::AXIL_SLVERR;
      end
   end

   assign wreq = wreq_q;

   always_comb begin
      bus_rsp.awready = aw_rdy_q;
      bus_rsp.wready  = aw_rdy_q;
      bus_rsp.bvalid  = bvalid_q;
      bus_rsp.bresp   = bresp_q;
      bus_rsp.arready = ~rvalid_q;
      bus_rsp.rvalid  = rvalid_q;
      bus_rsp.rdata   = rdata_q;
      bus_rsp.rresp   = rresp_q;
   end

endmodule

// ==== source/msr_top.sv ====
// ==================================================
// MSR block top
// Bus port, exception controller and register file
// ==================================================
`timescale 1ns/100ps
`include "msr_consts.svh"

module msr_top (
   input  logic                clk,
   input  logic                rst,
   input  axil_pkg::axil_req_t bus_req,
   output axil_pkg::axil_rsp_t bus_rsp,
   input  logic                exc_req,
   input  logic                eret,
   input  logic [`MSR_DW-1:0]  exc_pc,
   input  logic [`MSR_DW-1:0]  exc_lsa,
   output msr_pkg::psr_word_t  psr
);

   msr_pkg::msr_wreq_t              wreq;
   logic                            wreq_ready;
   logic                            wdone;
   logic                            exc_ent;
   logic [5:0]                      psr_we;
   msr_pkg::psr_word_t              psr_nxt;
   msr_pkg::psr_word_t              psr_nold;
   msr_pkg::psr_word_t              epsr_nxt;
   logic                            epsr_we;
   msr_pkg::psr_word_t              epsr;
   logic [`MSR_DW-1:0]              epc_nxt;
   logic                            epc_we;
   logic [`MSR_DW-1:0]              epc;
   logic [`MSR_DW-1:0]              elsa_nxt;
   logic                            elsa_we;
   logic [`MSR_DW-1:0]              elsa;
   logic [`MSR_DW-1:0]              sr_nxt;
   logic [`MSR_SR_NUM-1:0]          sr_we;
   logic [`MSR_SR_NUM*`MSR_DW-1:0]  sr;
   logic [`MSR_DW-1:0]              cpuid;
   logic [`MSR_DW-1:0]              coreid;

   msr_axil_port i_port (
      .clk, .rst, .bus_req, .bus_rsp, .wreq, .wreq_ready, .wdone,
      .psr, .epsr, .epc, .elsa, .cpuid, .coreid, .sr
   );

   exc_ctrl i_exc_ctrl (
      .clk, .rst, .exc_req, .exc_pc, .exc_lsa, .eret, .wreq, .wreq_ready, .wdone,
      .psr_nold, .epsr, .exc_ent, .psr_we, .psr_nxt, .epsr_nxt, .epsr_we,
      .epc_nxt, .epc_we, .elsa_nxt, .elsa_we, .sr_nxt, .sr_we
   );

   ex_psr i_ex_psr (
      .clk, .rst, .exc_ent, .psr_we, .psr_nxt, .psr, .psr_nold,
      .epsr_nxt, .epsr_we, .epsr, .epc_nxt, .epc_we, .epc,
      .elsa_nxt, .elsa_we, .elsa, .sr_nxt, .sr_we, .sr, .cpuid, .coreid
   );

endmodule

// ==== bench/tb_msr_top.sv ====
// ==================================================
// Testbench for the MSR block
// Table of bus and exception operations with a model
// ==================================================
`timescale 1ns/100ps
`include "msr_consts.svh"

module tb_msr_top;

   typedef enum logic [2:0] {OP_WR, OP_RD, OP_EXC, OP_RET, OP_WX} op_t;

   typedef struct packed {
      op_t         op;
      logic [5:0]  addr;
      logic [31:0] data;
      logic [31:0] pc;
      logic [31:0] lsa;
      logic [31:0] exp;
      logic [1:0]  resp;
   } row_t;

   localparam int          HS_LIMIT    = 20;
   localparam logic [1:0]  RESP_OKAY   = 2'b00;
   localparam logic [1:0]  RESP_SLVERR = 2'b10;
   localparam logic [9:0]  PSR_RM      = 10'h010;
   // ire, imme and dmme
   localparam logic [9:0]  PSR_EXC_CLR = 10'h0E0;
   localparam logic [31:0] CPUID_EXP   = (32'(`MSR_CPUID_FEAT) << 18) |
                                         (32'(`MSR_CPUID_REV) << 8) | 32'(`MSR_CPUID_VER);

   logic                clk;
   logic                rst;
   axil_pkg::axil_req_t bus_req;
   axil_pkg::axil_rsp_t bus_rsp;
   logic                exc_req;
   logic                eret;
   logic [31:0]         exc_pc;
   logic [31:0]         exc_lsa;
   msr_pkg::psr_word_t  psr_out;

   row_t        rows[$];
   logic [31:0] lfsr = 32'hb862;
   int          errors = 0;
   int          checks = 0;
   int          cycles = 0;
   int          cycle_limit = 100;
   int          errs_before;
   logic [5:0]  wr_addrs [8];

   // Register model
   logic [9:0]  m_psr;
   logic [9:0]  m_epsr;
   logic [31:0] m_epc;
   logic [31:0] m_elsa;
   logic [31:0] m_sr [4];

   msr_top i_msr_top (
      .clk, .rst, .bus_req, .bus_rsp, .exc_req, .eret, .exc_pc, .exc_lsa,
      .psr(psr_out)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // Galois LFSR stepped once per bit taken
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] val;
      val = '0;
      for (int i = 0; i < n; i++) begin
         val  = {val[30:0], lfsr[0]};
         lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h80200003 : 32'h0);
      end
      return val;
   endfunction

   function automatic string op_name(input op_t op);
      case (op)
         OP_WR:   return "write";
         OP_RD:   return "read";
         OP_EXC:  return "exception";
         OP_RET:  return "return";
         default: return "write+exception";
      endcase
   endfunction

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         $display("mismatch %s: got 0x%08h expected 0x%08h", name, got, exp);
         errors++;
      end
   endtask

   task automatic model_read(input logic [5:0] addr, output logic [31:0] val,
                             output logic [1:0] resp);
      resp = RESP_OKAY;
      case (addr)
         `MSR_ADDR_PSR:              val = {22'd0, m_psr};
         `MSR_ADDR_EPSR:             val = {22'd0, m_epsr};
         `MSR_ADDR_EPC:              val = m_epc;
         `MSR_ADDR_ELSA:             val = m_elsa;
         `MSR_ADDR_CPUID:            val = CPUID_EXP;
         `MSR_ADDR_COREID:           val = '0;
         6'h20, 6'h24, 6'h28, 6'h2C: val = m_sr[addr[3:2]];
         default: begin
            val  = '0;
            resp = RESP_SLVERR;
         end
      endcase
   endtask

   // Reserved PSR bits always land as zero
   task automatic model_write(input logic [5:0] addr, input logic [31:0] data,
                              output logic [1:0] resp);
      resp = RESP_OKAY;
      case (addr)
         `MSR_ADDR_PSR:              m_psr  = {data[9:4], 4'b0};
         `MSR_ADDR_EPSR:             m_epsr = {data[9:4], 4'b0};
         `MSR_ADDR_EPC:              m_epc  = data;
         `MSR_ADDR_ELSA:             m_elsa = data;
         6'h20, 6'h24, 6'h28, 6'h2C: m_sr[addr[3:2]] = data;
         default:                    resp = RESP_SLVERR;
      endcase
   endtask

   task automatic model_exc(input logic [31:0] pc, input logic [31:0] lsa);
      m_epsr = m_psr;
      m_epc  = pc;
      m_elsa = lsa;
      m_psr  = (m_psr | PSR_RM) & ~PSR_EXC_CLR;
   endtask

   task automatic add(input op_t op, input logic [5:0] addr, input logic [31:0] data,
                      input logic [31:0] pc, input logic [31:0] lsa);
      row_t r;
      r = '{op: op, addr: addr, data: data, pc: pc, lsa: lsa, exp: '0, resp: RESP_OKAY};
      case (op)
         OP_WR: model_write(addr, data, r.resp);
         OP_RD: model_read(addr, r.exp, r.resp);
         OP_EXC: begin
            model_exc(pc, lsa);
            r.exp = {22'd0, m_psr};
         end
         OP_RET: begin
            m_psr = m_epsr;
            r.exp = {22'd0, m_psr};
         end
         default: begin
            // Exception goes first and the held write follows
            model_exc(pc, lsa);
            model_write(addr, data, r.resp);
            r.exp = {22'd0, m_psr};
         end
      endcase
      rows.push_back(r);
   endtask

   task automatic build_table();
      logic [31:0] pc;
      logic [31:0] lsa;
      m_psr  = PSR_RM;
      m_epsr = '0;
      m_epc  = '0;
      m_elsa = '0;
      wr_addrs = '{`MSR_ADDR_PSR, 6'h20, 6'h24, 6'h28, 6'h2C,
                   `MSR_ADDR_EPC, `MSR_ADDR_ELSA, `MSR_ADDR_EPSR};
      // Reset values
      add(OP_RD, `MSR_ADDR_PSR, 0, 0, 0);
      add(OP_RD, `MSR_ADDR_EPSR, 0, 0, 0);
      add(OP_RD, `MSR_ADDR_EPC, 0, 0, 0);
      add(OP_RD, `MSR_ADDR_ELSA, 0, 0, 0);
      add(OP_RD, `MSR_ADDR_CPUID, 0, 0, 0);
      add(OP_RD, `MSR_ADDR_COREID, 0, 0, 0);
      foreach (wr_addrs[i]) begin
         add(OP_WR, wr_addrs[i], rand_bits(32), 0, 0);
         add(OP_RD, wr_addrs[i], 0, 0, 0);
      end
      // Exception entry and return
      pc  = rand_bits(32);
      lsa = rand_bits(32);
      add(OP_EXC, 0, 0, pc, lsa);
      add(OP_RD, `MSR_ADDR_EPSR, 0, 0, 0);
      add(OP_RD, `MSR_ADDR_EPC, 0, 0, 0);
      add(OP_RD, `MSR_ADDR_ELSA, 0, 0, 0);
      add(OP_RD, `MSR_ADDR_PSR, 0, 0, 0);
      add(OP_WR, `MSR_ADDR_PSR, rand_bits(32), 0, 0);
      add(OP_RET, 0, 0, 0, 0);
      add(OP_RD, `MSR_ADDR_PSR, 0, 0, 0);
      add(OP_RD, `MSR_ADDR_EPSR, 0, 0, 0);
      // Bus writes that collide with an exception
      add(OP_WX, 6'h28, rand_bits(32), rand_bits(32), rand_bits(32));
      add(OP_RD, 6'h28, 0, 0, 0);
      add(OP_RD, `MSR_ADDR_EPSR, 0, 0, 0);
      add(OP_RD, `MSR_ADDR_EPC, 0, 0, 0);
      add(OP_RD, `MSR_ADDR_ELSA, 0, 0, 0);
      add(OP_WX, `MSR_ADDR_PSR, rand_bits(32), rand_bits(32), rand_bits(32));
      add(OP_RD, `MSR_ADDR_PSR, 0, 0, 0);
      add(OP_RD, `MSR_ADDR_EPSR, 0, 0, 0);
      // Read-only and unmapped targets
      add(OP_WR, `MSR_ADDR_CPUID, rand_bits(32), 0, 0);
      add(OP_WR, `MSR_ADDR_COREID, rand_bits(32), 0, 0);
      add(OP_WR, 6'h3C, rand_bits(32), 0, 0);
      add(OP_RD, `MSR_ADDR_CPUID, 0, 0, 0);
      add(OP_RD, `MSR_ADDR_COREID, 0, 0, 0);
      add(OP_RD, 6'h18, 0, 0, 0);
      add(OP_RD, 6'h30, 0, 0, 0);
   endtask

   // Address and data phase ending one negedge after the handshake
   task automatic send_aw(input logic [5:0] addr, input logic [31:0] data);
      int n;
      n = 0;
      @(negedge clk);
      bus_req.awvalid = 1'b1;
      bus_req.awaddr  = addr;
      bus_req.wvalid  = 1'b1;
      bus_req.wdata   = data;
      while (!(bus_rsp.awready && bus_rsp.wready) && n < HS_LIMIT) begin
         @(negedge clk);
         n++;
      end
      if (!(bus_rsp.awready && bus_rsp.wready)) begin
         $display("write to 0x%02h saw no awready and wready within %0d cycles",
                  addr, HS_LIMIT);
         errors++;
      end
      @(negedge clk);
      bus_req.awvalid = 1'b0;
      bus_req.wvalid  = 1'b0;
   endtask

   task automatic wait_b(input logic [1:0] exp_resp);
      int n;
      n = 0;
      while (!bus_rsp.bvalid && n < HS_LIMIT) begin
         @(negedge clk);
         n++;
      end
      if (!bus_rsp.bvalid) begin
         $display("no write response arrived within %0d cycles", HS_LIMIT);
         errors++;
      end else begin
         check("bresp", 32'(bus_rsp.bresp), 32'(exp_resp));
      end
   endtask

   task automatic bus_write(input logic [5:0] addr, input logic [31:0] data,
                            input logic [1:0] exp_resp);
      send_aw(addr, data);
      wait_b(exp_resp);
   endtask

   task automatic bus_read(input logic [5:0] addr, input logic [31:0] exp,
                           input logic [1:0] exp_resp);
      int n;
      n = 0;
      @(negedge clk);
      bus_req.arvalid = 1'b1;
      bus_req.araddr  = addr;
      while (!bus_rsp.arready && n < HS_LIMIT) begin
         @(negedge clk);
         n++;
      end
      if (!bus_rsp.arready) begin
         $display("read of 0x%02h saw no arready within %0d cycles", addr, HS_LIMIT);
         errors++;
      end
      @(negedge clk);
      bus_req.arvalid = 1'b0;
      n = 0;
      while (!bus_rsp.rvalid && n < HS_LIMIT) begin
         @(negedge clk);
         n++;
      end
      if (!bus_rsp.rvalid) begin
         $display("read of 0x%02h got no read data within %0d cycles", addr, HS_LIMIT);
         errors++;
      end else begin
         check("rdata", bus_rsp.rdata, exp);
         check("rresp", 32'(bus_rsp.rresp), 32'(exp_resp));
      end
   endtask

   task automatic pulse_exc(input logic [31:0] pc, input logic [31:0] lsa,
                            input logic [31:0] exp_psr);
      @(negedge clk);
      exc_req = 1'b1;
      exc_pc  = pc;
      exc_lsa = lsa;
      @(negedge clk);
      check("psr", 32'(psr_out.raw), exp_psr);
      exc_req = 1'b0;
   endtask

   task automatic pulse_ret(input logic [31:0] exp_psr);
      @(negedge clk);
      eret = 1'b1;
      @(negedge clk);
      check("psr", 32'(psr_out.raw), exp_psr);
      eret = 1'b0;
   endtask

   // Exception lands in the cycle the port hands the write over
   task automatic write_during_exc(input row_t r);
      send_aw(r.addr, r.data);
      exc_req = 1'b1;
      exc_pc  = r.pc;
      exc_lsa = r.lsa;
      @(negedge clk);
      exc_req = 1'b0;
      wait_b(r.resp);
      check("psr", 32'(psr_out.raw), r.exp);
   endtask

   initial begin
      while (cycles <= cycle_limit) begin
         @(posedge clk);
         cycles++;
      end
      $display("run stopped after %0d cycles without finishing the table", cycle_limit);
      $display("Test failed");
      $finish;
   end

   initial begin
      rst     = 1'b1;
      bus_req = '0;
      bus_req.wstrb  = 4'hF;
      bus_req.bready = 1'b1;
      bus_req.rready = 1'b1;
      exc_req = 1'b0;
      eret    = 1'b0;
      exc_pc  = '0;
      exc_lsa = '0;
      build_table();
      cycle_limit = 40 * rows.size() + 100;
      repeat (5) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;

      foreach (rows[i]) begin
         errs_before = errors;
         case (rows[i].op)
            OP_WR:   bus_write(rows[i].addr, rows[i].data, rows[i].resp);
            OP_RD:   bus_read(rows[i].addr, rows[i].exp, rows[i].resp);
            OP_EXC:  pulse_exc(rows[i].pc, rows[i].lsa, rows[i].exp);
            OP_RET:  pulse_ret(rows[i].exp);
            default: write_during_exc(rows[i]);
         endcase
         $display("row %0d %s addr 0x%02h: %s", i, op_name(rows[i].op), rows[i].addr,
                  (errors == errs_before) ? "ok" : "bad");
      end

      $display("%0d rows, %0d checks, %0d errors", rows.size(), checks, errors);
      if (errors == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

// ==== vlog.f ====
+incdir+include
source/msr_pkg.sv
source/axil_pkg.sv
source/ex_psr.sv
source/exc_ctrl.sv
source/msr_axil_port.sv
source/msr_top.sv
bench/tb_msr_top.sv

// ==== run.sh ====
#!/bin/sh
# Build the MSR testbench with Verilator, run it and scan the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/100ps \
   -f vlog.f --top-module tb_msr_top -o tb_msr_top

./obj_dir/tb_msr_top | tee sim.log

if grep -q "Test passed" sim.log; then
   echo "run.sh: simulation passed"
   exit 0
else
   echo "run.sh: simulation did not pass"
   exit 1
fi
